//--- hdl/dekatron_consts.svh
`ifndef DEKATRON_CONSTS_SVH
`define DEKATRON_CONSTS_SVH

// One-hot positions per dekatron digit.
`define DEKATRON_WIDTH 10

// Digit counts of the counters.
`define IP_DEKATRON_NUM 3
`define AP_DEKATRON_NUM 3
`define DATA_DEKATRON_NUM 3
`define LOOP_DEKATRON_NUM 2

`define INSN_WIDTH 4

// Binary load address, wide enough for 1000 words.
`define PROG_ADDR_WIDTH 10
`define PROG_DEPTH 1000
`define DATA_DEPTH 1000

// Clk cycles between two tube steps.
`define STEP_DIVISOR 4

`endif

//--- hdl/DekatronPkg.sv
`include "dekatron_consts.svh"

package DekatronPkg;

    typedef enum logic [`INSN_WIDTH-1:0] {
        INSN_NOP        = 4'b0000,
        INSN_HALT       = 4'b0001,
        INSN_INC        = 4'b0010,
        INSN_DEC        = 4'b0011,
        INSN_RIGHT      = 4'b0100,
        INSN_LEFT       = 4'b0101,
        INSN_LOOP_BEGIN = 4'b0110,
        INSN_LOOP_END   = 4'b0111,
        INSN_OUT        = 4'b1000,
        INSN_DEBUG_MODE = 4'b1110,
        INSN_BF_MODE    = 4'b1111
    } insn_t;

    // Debug loops test the AP, Brainfuck loops test the cell.
    typedef enum logic {
        DEBUG_ISA     = 1'b0,
        BRAINFUCK_ISA = 1'b1
    } isaMode_t;

    typedef enum logic [2:0] {
        IDLE  = 3'b001,
        FETCH = 3'b010,
        EXEC  = 3'b011,
        HALT  = 3'b100
    } ctrlState_t;

    // One tube step of a single digit, up or down.
    function automatic logic [`DEKATRON_WIDTH-1:0] rotateDigit(
        input logic [`DEKATRON_WIDTH-1:0] digit,
        input logic dec
    );
        if (dec) begin
            return {digit[0], digit[`DEKATRON_WIDTH-1:1]};
        end
        return {digit[`DEKATRON_WIDTH-2:0], digit[`DEKATRON_WIDTH-1]};
    endfunction

    function automatic logic [3:0] digitToBin(input logic [`DEKATRON_WIDTH-1:0] digit);
        logic [3:0] pos;
        pos = '0;
        for (int k = 0; k < `DEKATRON_WIDTH; k++) begin
            if (digit[k]) begin
                pos = 4'(k);
            end
        end
        return pos;
    endfunction

endpackage

//--- hdl/LineBus.sv
`timescale 1ns/100ps

// Request/ready handshake between the controller and one counter line.
interface LineBus;
    logic Request;
    logic Dec;
    logic Ready;
    logic Zero;

    modport ctrl (
        output Request,
        output Dec,
        input  Ready,
        input  Zero
    );

    modport line (
        input  Request,
        input  Dec,
        output Ready,
        output Zero
    );
endinterface

//--- hdl/StepPulser.sv
`timescale 1ns/100ps
`include "dekatron_consts.svh"

module StepPulser (
    input  logic Clk,
    input  logic Rst_n,
    output logic Step
);
    localparam int CNT_W = $clog2(`STEP_DIVISOR);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`STEP_DIVISOR - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            count <= '0;
            Step <= 1'b0;
        end else begin
            // One enable per period, as slow as a tube can step.
            Step <= (count == CNT_LAST);
            if (count == CNT_LAST) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- hdl/DekatronCounter.sv
`timescale 1ns/100ps
`include "dekatron_consts.svh"

module DekatronCounter #(
    parameter int DIGITS = 3
) (
    input  logic Clk,
    input  logic Rst_n,
    input  logic Step,
    input  logic Request,
    input  logic Dec,
    output logic [DIGITS*`DEKATRON_WIDTH-1:0] Value,
    output logic Zero,
    output logic Busy
);
    import DekatronPkg::*;

    localparam int W = `DEKATRON_WIDTH;
    localparam logic [W-1:0] DIGIT_ZERO = {{(W-1){1'b0}}, 1'b1};

    logic pending;
    logic pendingDec;
    logic [DIGITS*W-1:0] nextValue;

    // Each digit moves only when every lower digit wraps.
    always_comb begin : rippleChain
        logic carry;
        logic [W-1:0] digit;
        carry = 1'b1;
        for (int i = 0; i < DIGITS; i++) begin
            digit = Value[i*W +: W];
            nextValue[i*W +: W] = carry ? rotateDigit(digit, pendingDec) : digit;
            carry = carry && (pendingDec ? digit[0] : digit[W-1]);
        end
    end

    always_comb begin
        Zero = 1'b1;
        for (int i = 0; i < DIGITS; i++) begin
            Zero = Zero && Value[i*W];
        end
    end

    assign Busy = pending;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            pending <= 1'b0;
            pendingDec <= 1'b0;
            Value <= {DIGITS{DIGIT_ZERO}};
        end else if (Request) begin
            pending <= 1'b1;
            pendingDec <= Dec;
        end else if (Step && pending) begin
            Value <= nextValue;
            pending <= 1'b0;
        end
    end

endmodule

//--- hdl/IpLine.sv
`timescale 1ns/100ps
`include "dekatron_consts.svh"

module IpLine (
    input  logic Clk,
    input  logic Rst_n,
    input  logic Step,
    input  logic Request,
    input  logic LoopValZero,
    input  logic ProgWe,
    input  logic [`PROG_ADDR_WIDTH-1:0] ProgAddr,
    input  DekatronPkg::insn_t ProgData,
    output logic Ready,
    output logic [`IP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] Address,
    output logic [`LOOP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] LoopCount,
    output DekatronPkg::insn_t Insn
);
    import DekatronPkg::*;

    localparam int W = `DEKATRON_WIDTH;
    localparam int IDX_W = `PROG_ADDR_WIDTH;
    localparam logic [IDX_W-1:0] PROG_LAST = IDX_W'(`PROG_DEPTH - 1);

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_MOVE,
        SC_SCAN
    } scanState_t;

    scanState_t scanState;
    scanState_t nextState;
    logic scanBack;
    logic started;
    logic ipReq;
    logic ipDec;
    logic ipBusy;
    logic loopReq;
    logic loopDec;
    logic loopBusy;
    logic loopZero;
    logic [IDX_W-1:0] ipIndex;
    insn_t progMem [`PROG_DEPTH];

    DekatronCounter #(.DIGITS(`IP_DEKATRON_NUM)) ipCounter (
        .Clk(Clk), .Rst_n(Rst_n), .Step(Step), .Request(ipReq), .Dec(ipDec),
        .Value(Address), .Zero(), .Busy(ipBusy)
    );

    DekatronCounter #(.DIGITS(`LOOP_DEKATRON_NUM)) loopCounter (
        .Clk(Clk), .Rst_n(Rst_n), .Step(Step), .Request(loopReq), .Dec(loopDec),
        .Value(LoopCount), .Zero(loopZero), .Busy(loopBusy)
    );

    always_comb begin
        ipIndex = '0;
        for (int i = `IP_DEKATRON_NUM - 1; i >= 0; i--) begin
            ipIndex = IDX_W'(ipIndex * 10 + digitToBin(Address[i*W +: W]));
        end
    end

    assign Insn = progMem[ipIndex];
    assign Ready = (scanState == SC_IDLE);

    always_ff @(posedge Clk) begin
        if (ProgWe && ProgAddr <= PROG_LAST) begin
            progMem[ProgAddr] <= ProgData;
        end
    end

    always_comb begin
        nextState = scanState;
        ipReq = 1'b0;
        ipDec = 1'b0;
        loopReq = 1'b0;
        loopDec = 1'b0;
        case (scanState)
            SC_IDLE: begin
                // Nothing moves on the very first request, so address 0 runs.
                if (Request) begin
                    nextState = SC_MOVE;
                    if (started) begin
                        ipReq = 1'b1;
                        if (Insn == INSN_LOOP_BEGIN && LoopValZero) begin
                            nextState = SC_SCAN;
                            loopReq = 1'b1;
                        end else if (Insn == INSN_LOOP_END && !LoopValZero) begin
                            nextState = SC_SCAN;
                            loopReq = 1'b1;
                            ipDec = 1'b1;
                        end
                    end
                end
            end
            SC_SCAN: begin
                if (!ipBusy && !loopBusy) begin
                    if (loopZero) begin
                        // Back scans overshoot by one and step onto the bracket.
                        if (scanBack) begin
                            ipReq = 1'b1;
                            nextState = SC_MOVE;
                        end else begin
                            nextState = SC_IDLE;
                        end
                    end else begin
                        ipReq = 1'b1;
                        ipDec = scanBack;
                        if (Insn == INSN_LOOP_BEGIN) begin
                            loopReq = 1'b1;
                            loopDec = scanBack;
                        end else if (Insn == INSN_LOOP_END) begin
                            loopReq = 1'b1;
                            loopDec = !scanBack;
                        end
                    end
                end
            end
            default: begin
                if (!ipBusy && !loopBusy) begin
                    nextState = SC_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            scanState <= SC_IDLE;
            scanBack <= 1'b0;
            started <= 1'b0;
        end else begin
            scanState <= nextState;
            if (scanState == SC_IDLE && Request) begin
                started <= 1'b1;
                scanBack <= ipDec;
            end
        end
    end

endmodule

//--- hdl/ApLine.sv
`timescale 1ns/100ps
`include "dekatron_consts.svh"

module ApLine (
    input  logic Clk,
    input  logic Rst_n,
    input  logic Step,
    LineBus.line apBus,
    LineBus.line dataBus,
    output logic [`AP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] Address,
    output logic [`DATA_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] Data
);
    import DekatronPkg::*;

    localparam int W = `DEKATRON_WIDTH;
    localparam int CELL_W = `DATA_DEKATRON_NUM * W;
    localparam int IDX_W = $clog2(`DATA_DEPTH);
    localparam logic [CELL_W-1:0] CELL_ZERO = {`DATA_DEKATRON_NUM{{{(W-1){1'b0}}, 1'b1}}};

    logic apBusy;
    logic lineReady;
    logic cellPending;
    logic cellDec;
    logic cellZero;
    logic [IDX_W-1:0] apIndex;
    logic [CELL_W-1:0] nextCell;
    logic [CELL_W-1:0] cells [`DATA_DEPTH];

    DekatronCounter #(.DIGITS(`AP_DEKATRON_NUM)) apCounter (
        .Clk(Clk), .Rst_n(Rst_n), .Step(Step), .Request(apBus.Request), .Dec(apBus.Dec),
        .Value(Address), .Zero(apBus.Zero), .Busy(apBusy)
    );

    always_comb begin
        apIndex = '0;
        for (int i = `AP_DEKATRON_NUM - 1; i >= 0; i--) begin
            apIndex = IDX_W'(apIndex * 10 + digitToBin(Address[i*W +: W]));
        end
    end

    assign Data = cells[apIndex];

    // Read-modify-write of the current cell, digit by digit.
    always_comb begin : cellChain
        logic carry;
        logic [W-1:0] digit;
        carry = 1'b1;
        cellZero = 1'b1;
        for (int i = 0; i < `DATA_DEKATRON_NUM; i++) begin
            digit = Data[i*W +: W];
            nextCell[i*W +: W] = carry ? rotateDigit(digit, cellDec) : digit;
            carry = carry && (cellDec ? digit[0] : digit[W-1]);
            cellZero = cellZero && digit[0];
        end
    end

    // One ready for both buses, since only one request is ever in flight.
    assign lineReady = !(apBusy || cellPending);
    assign apBus.Ready = lineReady;
    assign dataBus.Ready = lineReady;
    assign dataBus.Zero = cellZero;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            cellPending <= 1'b0;
            cellDec <= 1'b0;
            for (int a = 0; a < `DATA_DEPTH; a++) begin
                cells[a] <= CELL_ZERO;
            end
        end else if (dataBus.Request) begin
            cellPending <= 1'b1;
            cellDec <= dataBus.Dec;
        end else if (Step && cellPending) begin
            cells[apIndex] <= nextCell;
            cellPending <= 1'b0;
        end
    end

endmodule

//--- hdl/DekatronPC.sv
`timescale 1ns/100ps
`include "dekatron_consts.svh"

module DekatronPC (
    input  logic Clk,
    input  logic Rst_n,
    input  logic Halt,
    input  logic Step,
    input  logic Run,
    input  logic ProgWe,
    input  logic [`PROG_ADDR_WIDTH-1:0] ProgAddr,
    input  DekatronPkg::insn_t ProgData,
    output logic Cout,
    output logic [`IP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] IpAddress,
    output logic [`AP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] ApAddress,
    output logic [`DATA_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] Data,
    output logic [`LOOP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] LoopCount,
    output DekatronPkg::ctrlState_t CurrentState
);
    import DekatronPkg::*;

    logic stepPulse;
    logic ipRequest;
    logic ipReady;
    logic loopValZero;
    logic progWeHalted;
    logic apRequest;
    logic dataRequest;
    logic busDec;
    logic lineReady;
    insn_t insn;
    isaMode_t isaMode;

    LineBus apBus();
    LineBus dataBus();

    assign apBus.Request = apRequest;
    assign apBus.Dec = busDec;
    assign dataBus.Request = dataRequest;
    assign dataBus.Dec = busDec;
    assign lineReady = apBus.Ready && dataBus.Ready;

    assign loopValZero = (isaMode == BRAINFUCK_ISA) ? dataBus.Zero : apBus.Zero;
    // Program memory is only written while the machine stands still.
    assign progWeHalted = ProgWe && (CurrentState == HALT);

    StepPulser stepPulser (.Clk(Clk), .Rst_n(Rst_n), .Step(stepPulse));

    IpLine ipLine (
        .Clk(Clk), .Rst_n(Rst_n), .Step(stepPulse),
        .Request(ipRequest), .LoopValZero(loopValZero),
        .ProgWe(progWeHalted), .ProgAddr(ProgAddr), .ProgData(ProgData),
        .Ready(ipReady), .Address(IpAddress), .LoopCount(LoopCount), .Insn(insn)
    );

    ApLine apLine (
        .Clk(Clk), .Rst_n(Rst_n), .Step(stepPulse),
        .apBus(apBus), .dataBus(dataBus), .Address(ApAddress), .Data(Data)
    );

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            CurrentState <= HALT;
            ipRequest <= 1'b0;
            apRequest <= 1'b0;
            dataRequest <= 1'b0;
            busDec <= 1'b0;
            Cout <= 1'b0;
            isaMode <= BRAINFUCK_ISA;
        end else begin
            ipRequest <= 1'b0;
            apRequest <= 1'b0;
            dataRequest <= 1'b0;
            Cout <= 1'b0;
            case (CurrentState)
                IDLE: begin
                    if (Halt) begin
                        CurrentState <= HALT;
                    end else begin
                        ipRequest <= 1'b1;
                        CurrentState <= FETCH;
                    end
                end
                FETCH: begin
                    // Ready is still stale in the cycle the request is seen.
                    if (!ipRequest && ipReady) begin
                        case (insn)
                            INSN_HALT: CurrentState <= HALT;
                            INSN_INC, INSN_DEC: begin
                                dataRequest <= 1'b1;
                                busDec <= insn[0];
                                CurrentState <= EXEC;
                            end
                            INSN_RIGHT, INSN_LEFT: begin
                                apRequest <= 1'b1;
                                busDec <= insn[0];
                                CurrentState <= EXEC;
                            end
                            INSN_OUT: begin
                                Cout <= 1'b1;
                                ipRequest <= 1'b1;
                            end
                            INSN_DEBUG_MODE: begin
                                isaMode <= DEBUG_ISA;
                                ipRequest <= 1'b1;
                            end
                            INSN_BF_MODE: begin
                                isaMode <= BRAINFUCK_ISA;
                                ipRequest <= 1'b1;
                            end
                            default: ipRequest <= 1'b1;
                        endcase
                    end
                end
                EXEC: begin
                    if (!apRequest && !dataRequest && lineReady) begin
                        if (Halt || Step) begin
                            CurrentState <= HALT;
                        end else begin
                            ipRequest <= 1'b1;
                            CurrentState <= FETCH;
                        end
                    end
                end
                HALT: begin
                    if (Step || Run) begin
                        CurrentState <= IDLE;
                    end
                end
                default: CurrentState <= HALT;
            endcase
        end
    end

endmodule

//--- test/DekatronPC_assertions.sv
`timescale 1ns/100ps

module DekatronPC_assertions (
    input logic Clk,
    input logic Rst_n,
    input logic apRequest,
    input logic dataRequest,
    input logic lineReady,
    input logic ipRequest,
    input logic ipReady,
    input logic Cout,
    input DekatronPkg::ctrlState_t CurrentState
);
    import DekatronPkg::*;

    int failures = 0;

    // The controller only asks a line that has settled.
    apReqWhileReady: assert property (@(posedge Clk) disable iff (!Rst_n)
        apRequest |-> lineReady)
        else begin
            $error("AP request issued while the address line was busy");
            failures++;
        end

    dataReqWhileReady: assert property (@(posedge Clk) disable iff (!Rst_n)
        dataRequest |-> lineReady)
        else begin
            $error("Cell request issued while the address line was busy");
            failures++;
        end

    ipReqWhileReady: assert property (@(posedge Clk) disable iff (!Rst_n)
        ipRequest |-> ipReady)
        else begin
            $error("IP request issued while the instruction line was busy");
            failures++;
        end

    legalState: assert property (@(posedge Clk) disable iff (!Rst_n)
        CurrentState inside {IDLE, FETCH, EXEC, HALT})
        else begin
            $error("Controller state left the four legal codes");
            failures++;
        end

    // Output strobe is a single cycle wide.
    coutPulse: assert property (@(posedge Clk) disable iff (!Rst_n)
        Cout |=> !Cout)
        else begin
            $error("Cout stayed high for more than one cycle");
            failures++;
        end

endmodule

//--- test/DekatronPC_tb.sv
`timescale 1ns/100ps
`include "dekatron_consts.svh"

module DekatronPC_tb;
    import DekatronPkg::*;

    localparam int NUM_TESTS = 5;
    localparam int NUM_W = `DATA_DEKATRON_NUM * `DEKATRON_WIDTH;

    logic Clk;
    logic Rst_n;
    logic Halt;
    logic Step;
    logic Run;
    logic ProgWe;
    logic [`PROG_ADDR_WIDTH-1:0] ProgAddr;
    insn_t ProgData;
    logic Cout;
    logic [`IP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] IpAddress;
    logic [`AP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] ApAddress;
    logic [`DATA_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] Data;
    logic [`LOOP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] LoopCount;
    ctrlState_t CurrentState;

    int errorCount = 0;
    int cycleCount = 0;
    int outData[$];
    int outAp[$];
    int refData[$];
    int refAp[$];
    int refFinalAp;
    int refHaltIp;

    // Programs are hex strings, one instruction code per character.
    string testName [NUM_TESTS] = '{"arith", "pointer", "loops", "debug", "step"};
    string testProg [NUM_TESTS] = '{"2222222222228381", "22842855381",
        "626277222226342578481", "E444265278F63781", "2222222222228381"};
    int expCount [NUM_TESTS] = '{2, 3, 2, 2, 2};
    int expData [NUM_TESTS][3] = '{'{12, 11, 0}, '{2, 1, 999}, '{0, 5, 0},
        '{1, 0, 0}, '{12, 11, 0}};
    int expAp [NUM_TESTS][3] = '{'{0, 0, 0}, '{0, 1, 999}, '{0, 1, 0},
        '{0, 0, 0}, '{0, 0, 0}};
    int expFinalAp [NUM_TESTS] = '{0, 999, 1, 0, 0};
    // The IP rests on the HALT instruction that stopped the run.
    int expHaltIp [NUM_TESTS] = '{15, 10, 20, 15, 15};
    bit stepFirst [NUM_TESTS] = '{0, 0, 0, 0, 1};
    int expStepData [NUM_TESTS] = '{0, 0, 0, 0, 1};

    DekatronPC dut (.*);

    bind DekatronPC DekatronPC_assertions assertChecks (.*);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    function automatic logic [3:0] hexNibble(input byte ch);
        if (ch >= 8'h30 && ch <= 8'h39) begin
            return 4'(ch - 8'h30);
        end
        if (ch >= 8'h41 && ch <= 8'h46) begin
            return 4'(ch - 8'h41 + 10);
        end
        return 4'h0;
    endfunction

    function automatic int digitsToInt(input logic [NUM_W-1:0] value, input int digits);
        int result;
        int hot;
        int pos;
        result = 0;
        for (int d = digits - 1; d >= 0; d--) begin
            hot = 0;
            pos = 0;
            for (int k = 0; k < `DEKATRON_WIDTH; k++) begin
                if (value[d*`DEKATRON_WIDTH + k]) begin
                    hot++;
                    pos = k;
                end
            end
            // A tube with no glow or two glows is a broken digit.
            if (hot != 1) begin
                return -1;
            end
            result = result * 10 + pos;
        end
        return result;
    endfunction

    task automatic checkValue(input string name, input string what, input int expected,
                              input int actual);
        assert (actual == expected) else begin
            $display("Fail %s: %s expected %0d, actual %0d", name, what, expected, actual);
            errorCount++;
        end
    endtask

    // Reference Brainfuck model with decimal cells and the debug loop test.
    task automatic interpretProgram(input string prog);
        int cells [`DATA_DEPTH];
        int ap;
        int pc;
        int depth;
        int guard;
        bit debugMode;
        bit isZero;
        logic [3:0] code;
        foreach (cells[i]) cells[i] = 0;
        ap = 0;
        pc = 0;
        guard = 0;
        debugMode = 1'b0;
        refHaltIp = -1;
        refData.delete();
        refAp.delete();
        while (pc < prog.len() && guard < 100000) begin
            code = hexNibble(prog[pc]);
            isZero = debugMode ? (ap == 0) : (cells[ap] == 0);
            guard++;
            case (code)
                4'h1: begin
                    refHaltIp = pc;
                    pc = prog.len();
                end
                4'h2: cells[ap] = (cells[ap] + 1) % 1000;
                4'h3: cells[ap] = (cells[ap] + 999) % 1000;
                4'h4: ap = (ap + 1) % 1000;
                4'h5: ap = (ap + 999) % 1000;
                4'h6: begin
                    depth = isZero ? 1 : 0;
                    while (depth > 0) begin
                        pc++;
                        if (hexNibble(prog[pc]) == 4'h6) depth++;
                        if (hexNibble(prog[pc]) == 4'h7) depth--;
                    end
                end
                4'h7: begin
                    depth = isZero ? 0 : 1;
                    while (depth > 0) begin
                        pc--;
                        if (hexNibble(prog[pc]) == 4'h7) depth++;
                        if (hexNibble(prog[pc]) == 4'h6) depth--;
                    end
                end
                4'h8: begin
                    refData.push_back(cells[ap]);
                    refAp.push_back(ap);
                end
                4'hE: debugMode = 1'b1;
                4'hF: debugMode = 1'b0;
                default: ;
            endcase
            pc++;
        end
        refFinalAp = ap;
    endtask

    task automatic resetDut();
        @(negedge Clk);
        Rst_n = 1'b0;
        repeat (3) @(negedge Clk);
        Rst_n = 1'b1;
    endtask

    task automatic loadProgram(input string prog);
        for (int i = 0; i < prog.len(); i++) begin
            @(negedge Clk);
            ProgWe = 1'b1;
            ProgAddr = `PROG_ADDR_WIDTH'(i);
            ProgData = insn_t'(hexNibble(prog[i]));
        end
        @(negedge Clk);
        ProgWe = 1'b0;
    endtask

    task automatic runUntilHalt();
        @(negedge Clk);
        Run = 1'b1;
        @(negedge Clk);
        Run = 1'b0;
        while (CurrentState == HALT) begin
            @(negedge Clk);
        end
        while (CurrentState != HALT) begin
            @(negedge Clk);
        end
    endtask

    // Step stays high through one instruction and drops as soon as HALT shows.
    task automatic stepOnce();
        @(negedge Clk);
        Step = 1'b1;
        @(negedge Clk);
        while (CurrentState == HALT) begin
            @(negedge Clk);
        end
        while (CurrentState != HALT) begin
            @(negedge Clk);
        end
        Step = 1'b0;
    endtask

    always @(negedge Clk) begin
        if (Rst_n && Cout) begin
            outData.push_back(digitsToInt(Data, `DATA_DEKATRON_NUM));
            outAp.push_back(digitsToInt(ApAddress, `AP_DEKATRON_NUM));
        end
    end

    initial begin : watchdog
        int limit;
        limit = 0;
        foreach (testProg[t]) begin
            limit += testProg[t].len() * 40 * `STEP_DIVISOR;
        end
        while (cycleCount < limit) begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("Timeout: the machine did not reach HALT within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

    initial begin : main
        int testErrors;
        int failedTests;
        string name;
        Rst_n = 1'b0;
        Halt = 1'b0;
        Step = 1'b0;
        Run = 1'b0;
        ProgWe = 1'b0;
        ProgAddr = '0;
        ProgData = INSN_NOP;
        failedTests = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            name = testName[t];
            testErrors = errorCount;
            interpretProgram(testProg[t]);
            checkValue(name, "model Cout count", expCount[t], refData.size());
            for (int i = 0; i < expCount[t] && i < refData.size(); i++) begin
                checkValue(name, $sformatf("model Cout %0d data", i), expData[t][i], refData[i]);
                checkValue(name, $sformatf("model Cout %0d AP", i), expAp[t][i], refAp[i]);
            end
            checkValue(name, "model final AP", expFinalAp[t], refFinalAp);
            checkValue(name, "model halt IP", expHaltIp[t], refHaltIp);
            resetDut();
            outData.delete();
            outAp.delete();
            loadProgram(testProg[t]);
            if (stepFirst[t]) begin
                stepOnce();
                checkValue(name, "IP after step", 0,
                    digitsToInt(IpAddress, `IP_DEKATRON_NUM));
                checkValue(name, "data after step", expStepData[t],
                    digitsToInt(Data, `DATA_DEKATRON_NUM));
                checkValue(name, "AP after step", 0, digitsToInt(ApAddress, `AP_DEKATRON_NUM));
            end
            runUntilHalt();
            checkValue(name, "Cout count", expCount[t], outData.size());
            for (int i = 0; i < expCount[t] && i < outData.size(); i++) begin
                checkValue(name, $sformatf("Cout %0d data", i), expData[t][i], outData[i]);
                checkValue(name, $sformatf("Cout %0d AP", i), expAp[t][i], outAp[i]);
            end
            checkValue(name, "final AP", expFinalAp[t], digitsToInt(ApAddress, `AP_DEKATRON_NUM));
            checkValue(name, "halt IP", expHaltIp[t],
                digitsToInt(IpAddress, `IP_DEKATRON_NUM));
            checkValue(name, "loop count", 0, digitsToInt(NUM_W'(LoopCount), `LOOP_DEKATRON_NUM));
            if (errorCount != testErrors) begin
                failedTests++;
            end
            $display("Test %s: %s", name, (errorCount == testErrors) ? "ok" : "FAILED");
        end
        errorCount += dut.assertChecks.failures;
        $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
            NUM_TESTS, failedTests, errorCount, dut.assertChecks.failures);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hdl
hdl/DekatronPkg.sv
hdl/LineBus.sv
hdl/StepPulser.sv
hdl/DekatronCounter.sv
hdl/IpLine.sv
hdl/ApLine.sv
hdl/DekatronPC.sv
test/DekatronPC_assertions.sv
test/DekatronPC_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := DekatronPC_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
SIM_FLAGS := +verilator+error+limit+100
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
